// File: Makefile
TOOL   := verilator
TOP    := tb_cache_axi_bridge
FLIST  := files.f
FLAGS  := --timing --assert --timescale 1ns/100ps
OBJDIR := obj_dir
LOG    := sim.log
FAIL   := test failed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL)" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@grep -q "test passed" $(LOG) || { echo "no result line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: files.f
hdl/bridge_pkg.sv
hdl/bridge_ctrl.sv
hdl/ar_channel.sv
hdl/r_router.sv
hdl/w_channel.sv
hdl/cache_axi_bridge.sv
verification/tb_clock.sv
verification/tb_cache_axi_bridge.sv

// File: hdl/ar_channel.sv
`default_nettype none

module ar_channel (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   ar_load_i,
    input  bridge_pkg::rd_src_e    rd_src_i,
    input  bridge_pkg::cache_req_t ic_req_i,
    input  bridge_pkg::cache_req_t dc_req_i,
    input  logic                   arready_i,
    output bridge_pkg::axi_a_t     ar_o,
    output logic                   arvalid_o,
    output logic                   ar_fire_o
);
    import bridge_pkg::*;

    cache_req_t req;
    axi_a_t     ar_q;
    logic       arvalid_q;

    assign req = (rd_src_i == SRC_ICACHE) ? ic_req_i : dc_req_i;

    // payload, held until the handshake
    always_ff @(posedge clk) begin
        if (ar_load_i) begin
            ar_q.id    <= (rd_src_i == SRC_ICACHE) ? ICACHE_ID : DCACHE_ID;
            ar_q.addr  <= req.addr;
            ar_q.len   <= req.cnt - LEN_W'(1);  // axi len is beats minus one
            ar_q.size  <= SIZE_WORD;
            ar_q.burst <= BURST_INCR;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            arvalid_q <= 1'b0;
        end else if (ar_load_i) begin
            arvalid_q <= 1'b1;
        end else if (ar_fire_o) begin
            arvalid_q <= 1'b0;
        end
    end

    assign ar_o      = ar_q;
    assign arvalid_o = arvalid_q;
    assign ar_fire_o = arvalid_q && arready_i;

    a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        arvalid_o && !arready_i |=> arvalid_o && $stable(ar_o));

endmodule

`default_nettype wire

// File: hdl/bridge_ctrl.sv
`default_nettype none

module bridge_ctrl (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                ic_rd_req_i,
    input  logic                dc_rd_req_i,
    input  logic                dc_wr_req_i,
    input  logic                ar_fire_i,
    input  logic                rd_done_i,
    input  logic                aw_fire_i,
    input  logic                w_done_i,
    input  logic                bvalid_i,
    output logic                ar_load_o,
    output bridge_pkg::rd_src_e rd_src_o,
    output logic                rd_open_o,
    output logic                ic_ar_ready_o,
    output logic                dc_ar_ready_o,
    output logic                aw_load_o,
    output logic                w_open_o,
    output logic                bready_o,
    output logic                dc_aw_ready_o
);
    import bridge_pkg::*;

    rd_state_e rd_state_q;
    rd_state_e rd_state_d;
    wr_state_e wr_state_q;
    wr_state_e wr_state_d;
    rd_src_e   owner_q;  // current or last read owner
    rd_src_e   grant;

    // round robin, the side that did not own the last read wins a tie
    always_comb begin
        if (ic_rd_req_i && dc_rd_req_i) begin
            grant = (owner_q == SRC_DCACHE) ? SRC_ICACHE : SRC_DCACHE;
        end else if (ic_rd_req_i) begin
            grant = SRC_ICACHE;
        end else begin
            grant = SRC_DCACHE;
        end
    end

    always_comb begin
        rd_state_d = rd_state_q;
        ar_load_o  = 1'b0;
        case (rd_state_q)
            RD_IDLE: begin
                if (ic_rd_req_i || dc_rd_req_i) begin
                    ar_load_o  = 1'b1;
                    rd_state_d = RD_ADDR;
                end
            end
            RD_ADDR: if (ar_fire_i) rd_state_d = RD_DATA;
            RD_DATA: if (rd_done_i) rd_state_d = RD_IDLE;  // rlast taken
            default: rd_state_d = RD_IDLE;
        endcase
    end

    always_comb begin
        wr_state_d = wr_state_q;
        aw_load_o  = 1'b0;
        case (wr_state_q)
            WR_IDLE: begin
                if (dc_wr_req_i) begin
                    aw_load_o  = 1'b1;
                    wr_state_d = WR_ADDR;
                end
            end
            WR_ADDR: if (aw_fire_i) wr_state_d = WR_DATA;
            WR_DATA: if (w_done_i) wr_state_d = WR_RESP;
            WR_RESP: if (bvalid_i) wr_state_d = WR_IDLE;
            default: wr_state_d = WR_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rd_state_q <= RD_IDLE;
            wr_state_q <= WR_IDLE;
            owner_q    <= SRC_ICACHE;  // so the dcache wins first
        end else begin
            rd_state_q <= rd_state_d;
            wr_state_q <= wr_state_d;
            if (ar_load_o) owner_q <= grant;
        end
    end

    assign rd_src_o  = (rd_state_q == RD_IDLE) ? grant : owner_q;
    assign rd_open_o = (rd_state_q == RD_DATA);

    // ready pulses land on the AR handshake
    assign ic_ar_ready_o = ar_fire_i && (owner_q == SRC_ICACHE);
    assign dc_ar_ready_o = ar_fire_i && (owner_q == SRC_DCACHE);

    assign dc_aw_ready_o = aw_fire_i && (wr_state_q == WR_ADDR);
    assign w_open_o      = (wr_state_q == WR_DATA);
    assign bready_o      = (wr_state_q == WR_RESP);

    // an AR handshake only lands while the address phase waits for it
    a_ar_fire_phase: assert property (@(posedge clk) disable iff (!rst_n_i)
        ar_fire_i |-> (rd_state_q == RD_ADDR));

    a_aw_fire_phase: assert property (@(posedge clk) disable iff (!rst_n_i)
        aw_fire_i |-> (wr_state_q == WR_ADDR));

endmodule

`default_nettype wire

// File: hdl/bridge_pkg.sv
`default_nettype none

package bridge_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;
    localparam int ID_W   = 4;
    localparam int LEN_W  = 8;

    // fixed field values
    localparam logic [ID_W-1:0] ICACHE_ID  = 4'd1;
    localparam logic [ID_W-1:0] DCACHE_ID  = 4'd0;
    localparam logic [2:0]      SIZE_WORD  = 3'd2; // 4 bytes per beat
    localparam logic [1:0]      BURST_INCR = 2'd1;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_e;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_e;

    // read owner, encoded the same as the arid
    typedef enum logic {
        SRC_DCACHE = 1'b0,
        SRC_ICACHE = 1'b1
    } rd_src_e;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  cnt;   // beats, not axi len
    } cache_req_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        logic [2:0]        size;
        logic [1:0]        burst;
    } axi_a_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } axi_w_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
        logic              last;
    } axi_r_t;

endpackage

`default_nettype wire

// File: hdl/cache_axi_bridge.sv
`default_nettype none

module cache_axi_bridge (
    input  logic                   clk,
    input  logic                   rst_n_i,
    // cache side
    input  logic                   ic_rd_req_i,
    input  bridge_pkg::cache_req_t ic_req_i,
    input  logic                   dc_rd_req_i,
    input  bridge_pkg::cache_req_t dc_req_i,
    input  logic                   dc_wr_req_i,
    input  bridge_pkg::cache_req_t dc_wr_i,
    input  logic                   dc_w_valid_i,
    input  bridge_pkg::axi_w_t     dc_w_i,
    output logic                   ic_ar_ready_o,
    output logic                   dc_ar_ready_o,
    output logic                   ic_r_valid_o,
    output logic                   dc_r_valid_o,
    output bridge_pkg::axi_w_t     cache_r_o,
    output logic                   dc_aw_ready_o,
    output logic                   dc_w_ready_o,
    // axi side
    output bridge_pkg::axi_a_t     ar_o,
    output logic                   arvalid_o,
    input  logic                   arready_i,
    input  logic                   rvalid_i,
    input  bridge_pkg::axi_r_t     r_i,
    output logic                   rready_o,
    output bridge_pkg::axi_a_t     aw_o,
    output logic                   awvalid_o,
    input  logic                   awready_i,
    output bridge_pkg::axi_w_t     w_o,
    output logic                   wvalid_o,
    input  logic                   wready_i,
    input  logic                   bvalid_i,
    input  logic [1:0]             bresp_i,
    output logic                   bready_o
);
    import bridge_pkg::*;

    logic    ar_load;
    rd_src_e rd_src;
    logic    rd_open;
    logic    ar_fire;
    logic    rd_done;
    logic    aw_load;
    logic    w_open;
    logic    aw_fire;
    logic    w_done;

    bridge_ctrl u_ctrl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .ic_rd_req_i  (ic_rd_req_i),
        .dc_rd_req_i  (dc_rd_req_i),
        .dc_wr_req_i  (dc_wr_req_i),
        .ar_fire_i    (ar_fire),
        .rd_done_i    (rd_done),
        .aw_fire_i    (aw_fire),
        .w_done_i     (w_done),
        .bvalid_i     (bvalid_i),
        .ar_load_o    (ar_load),
        .rd_src_o     (rd_src),
        .rd_open_o    (rd_open),
        .ic_ar_ready_o(ic_ar_ready_o),
        .dc_ar_ready_o(dc_ar_ready_o),
        .aw_load_o    (aw_load),
        .w_open_o     (w_open),
        .bready_o     (bready_o),
        .dc_aw_ready_o(dc_aw_ready_o)
    );

    ar_channel u_ar (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .ar_load_i(ar_load),
        .rd_src_i (rd_src),
        .ic_req_i (ic_req_i),
        .dc_req_i (dc_req_i),
        .arready_i(arready_i),
        .ar_o     (ar_o),
        .arvalid_o(arvalid_o),
        .ar_fire_o(ar_fire)
    );

    r_router u_r (
        .rd_open_i   (rd_open),
        .rvalid_i    (rvalid_i),
        .r_i         (r_i),
        .rready_o    (rready_o),
        .ic_r_valid_o(ic_r_valid_o),
        .dc_r_valid_o(dc_r_valid_o),
        .cache_r_o   (cache_r_o),
        .rd_done_o   (rd_done)
    );

    w_channel u_w (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .aw_load_i   (aw_load),
        .w_open_i    (w_open),
        .dc_wr_i     (dc_wr_i),
        .awready_i   (awready_i),
        .dc_w_valid_i(dc_w_valid_i),
        .dc_w_i      (dc_w_i),
        .wready_i    (wready_i),
        .aw_o        (aw_o),
        .awvalid_o   (awvalid_o),
        .aw_fire_o   (aw_fire),
        .w_o         (w_o),
        .wvalid_o    (wvalid_o),
        .dc_w_ready_o(dc_w_ready_o),
        .w_done_o    (w_done)
    );

    // the dcache has no error path, so a write must complete OKAY
    a_bresp_okay: assert property (@(posedge clk) disable iff (!rst_n_i)
        bvalid_i && bready_o |-> bresp_i == 2'b00);

endmodule

`default_nettype wire

// File: hdl/r_router.sv
`default_nettype none

module r_router (
    input  logic               rd_open_i,
    input  logic               rvalid_i,
    input  bridge_pkg::axi_r_t r_i,
    output logic               rready_o,
    output logic               ic_r_valid_o,
    output logic               dc_r_valid_o,
    output bridge_pkg::axi_w_t cache_r_o,
    output logic               rd_done_o
);
    import bridge_pkg::*;

    logic beat;

    assign rready_o = rd_open_i;  // caches never stall reads
    assign beat     = rvalid_i && rd_open_i;

    // steer by rid
    assign ic_r_valid_o = beat && (r_i.id == ICACHE_ID);
    assign dc_r_valid_o = beat && (r_i.id == DCACHE_ID);

    assign cache_r_o.data = r_i.data;
    assign cache_r_o.strb = '1;      // always a full word
    assign cache_r_o.last = r_i.last;

    assign rd_done_o = beat && r_i.last;

    // the slave may only return data for an open read burst
    a_r_in_burst: assert property (@(posedge rvalid_i) rd_open_i);

endmodule

`default_nettype wire

// File: hdl/w_channel.sv
`default_nettype none

module w_channel (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   aw_load_i,
    input  logic                   w_open_i,
    input  bridge_pkg::cache_req_t dc_wr_i,
    input  logic                   awready_i,
    input  logic                   dc_w_valid_i,
    input  bridge_pkg::axi_w_t     dc_w_i,
    input  logic                   wready_i,
    output bridge_pkg::axi_a_t     aw_o,
    output logic                   awvalid_o,
    output logic                   aw_fire_o,
    output bridge_pkg::axi_w_t     w_o,
    output logic                   wvalid_o,
    output logic                   dc_w_ready_o,
    output logic                   w_done_o
);
    import bridge_pkg::*;

    axi_a_t aw_q;
    logic   awvalid_q;

    // only the dcache writes
    always_ff @(posedge clk) begin
        if (aw_load_i) begin
            aw_q.id    <= DCACHE_ID;
            aw_q.addr  <= dc_wr_i.addr;
            aw_q.len   <= dc_wr_i.cnt - LEN_W'(1);
            aw_q.size  <= SIZE_WORD;
            aw_q.burst <= BURST_INCR;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            awvalid_q <= 1'b0;
        end else if (aw_load_i) begin
            awvalid_q <= 1'b1;
        end else if (aw_fire_o) begin
            awvalid_q <= 1'b0;
        end
    end

    assign aw_o      = aw_q;
    assign awvalid_o = awvalid_q;
    assign aw_fire_o = awvalid_q && awready_i;

    // W beats flow straight through once AW is accepted
    assign w_o          = dc_w_i;
    assign wvalid_o     = w_open_i && dc_w_valid_i;
    assign dc_w_ready_o = w_open_i && wready_i;
    assign w_done_o     = wvalid_o && wready_i && dc_w_i.last;

    a_aw_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        awvalid_o && !awready_i |=> awvalid_o && $stable(aw_o));

endmodule

`default_nettype wire

// File: verification/tb_cache_axi_bridge.sv
`default_nettype none

module tb_cache_axi_bridge;
    timeunit 1ns;
    timeprecision 100ps;

    import bridge_pkg::*;

    localparam int N_IC    = 4;
    localparam int N_DC    = 4;
    localparam int N_BOTH  = 3;  // pairs of reads
    localparam int N_WR    = 4;
    localparam int N_TRANS = N_IC + N_DC + 2 * N_BOTH + N_WR;

    logic       clk;
    logic       rst_n_i;
    logic       ic_rd_req_i;
    cache_req_t ic_req_i;
    logic       dc_rd_req_i;
    cache_req_t dc_req_i;
    logic       dc_wr_req_i;
    cache_req_t dc_wr_i;
    logic       dc_w_valid_i;
    axi_w_t     dc_w_i;
    logic       ic_ar_ready_o;
    logic       dc_ar_ready_o;
    logic       ic_r_valid_o;
    logic       dc_r_valid_o;
    axi_w_t     cache_r_o;
    logic       dc_aw_ready_o;
    logic       dc_w_ready_o;
    axi_a_t     ar_o;
    logic       arvalid_o;
    logic       arready_i;
    logic       rvalid_i;
    axi_r_t     r_i;
    logic       rready_o;
    axi_a_t     aw_o;
    logic       awvalid_o;
    logic       awready_i;
    axi_w_t     w_o;
    logic       wvalid_o;
    logic       wready_i;
    logic       bvalid_i;
    logic [1:0] bresp_i;
    logic       bready_o;

    int    err_count;
    string test_name;

    // reference state kept by the testbench
    logic              last_was_ic;
    logic              rd_is_ic;
    logic [ADDR_W-1:0] rd_addr;
    logic [7:0]        rd_cnt;
    logic [7:0]        beat_k;
    logic [7:0]        wr_cnt;
    logic [7:0]        w_k;
    logic [DATA_W-1:0] wdata [8];
    logic [STRB_W-1:0] wstrb [8];

    logic       exp_ic_wins;
    cache_req_t exp_src;
    axi_a_t     exp_ar;
    axi_a_t     exp_aw;
    axi_w_t     exp_w;
    logic [DATA_W-1:0] exp_rdata;
    logic       exp_rlast;

    tb_clock u_clk (.clk_o(clk));

    cache_axi_bridge dut (.*);

    function automatic logic [DATA_W-1:0] pattern_word(input logic [ADDR_W-1:0] addr,
                                                       input logic [7:0] k);
        return (addr + (32'(k) << 2)) ^ 32'hA5A5_0000;
    endfunction

    function automatic logic [ADDR_W-1:0] rand_addr();
        return $urandom() & 32'hFFFF_FFFC;  // word aligned
    endfunction

    function automatic logic [7:0] rand_cnt();
        return 8'($urandom_range(1, 8));
    endfunction

    task automatic report_fail(input string check, input logic [63:0] exp,
                               input logic [63:0] act);
        err_count++;
        $display("Fail %s %s: expected %h, actual %h", test_name, check, exp, act);
    endtask

    task automatic report_problem(input string what);
        err_count++;
        $display("Error in %s: %s", test_name, what);
    endtask

    // tie goes to the side that did not own the last read
    assign exp_ic_wins = ic_rd_req_i && (!dc_rd_req_i || !last_was_ic);

    always_comb begin
        exp_src      = exp_ic_wins ? ic_req_i : dc_req_i;
        exp_ar.id    = exp_ic_wins ? ICACHE_ID : DCACHE_ID;
        exp_ar.addr  = exp_src.addr;
        exp_ar.len   = exp_src.cnt - 8'd1;
        exp_ar.size  = 3'd2;
        exp_ar.burst = 2'd1;
        exp_aw.id    = DCACHE_ID;
        exp_aw.addr  = dc_wr_i.addr;
        exp_aw.len   = dc_wr_i.cnt - 8'd1;
        exp_aw.size  = 3'd2;
        exp_aw.burst = 2'd1;
        exp_w.data   = wdata[w_k[2:0]];
        exp_w.strb   = wstrb[w_k[2:0]];
        exp_w.last   = (w_k == wr_cnt - 8'd1);
        exp_rdata    = pattern_word(rd_addr, beat_k);
        exp_rlast    = (beat_k == rd_cnt - 8'd1);
    end

    a_reset_quiet: assert property (@(posedge clk) $rose(rst_n_i) |->
        !(arvalid_o || awvalid_o || wvalid_o || rready_o || bready_o || ic_ar_ready_o ||
          dc_ar_ready_o || ic_r_valid_o || dc_r_valid_o || dc_aw_ready_o || dc_w_ready_o))
        else report_problem("control outputs were not all low after reset");

    a_ar_fields: assert property (@(posedge clk) disable iff (!rst_n_i)
        arvalid_o && arready_i |-> ar_o == exp_ar)
        else report_fail("ar payload", 64'(exp_ar), 64'(ar_o));

    a_ar_ready: assert property (@(posedge clk) disable iff (!rst_n_i)
        arvalid_o && arready_i |->
            ic_ar_ready_o == exp_ic_wins && dc_ar_ready_o == !exp_ic_wins)
        else report_fail("ar ready pulse", 64'({exp_ic_wins, !exp_ic_wins}),
                         64'({ic_ar_ready_o, dc_ar_ready_o}));

    a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        arvalid_o && !arready_i |=> arvalid_o && $stable(ar_o))
        else report_problem("AR valid or payload changed while arready was low");

    a_one_read: assert property (@(posedge clk) disable iff (!rst_n_i)
        rready_o |-> !arvalid_o)
        else report_problem("AR issued while a read burst was open");

    a_r_taken: assert property (@(posedge clk) disable iff (!rst_n_i)
        rvalid_i && rready_o |-> ic_r_valid_o || dc_r_valid_o)
        else report_problem("an R beat reached neither cache");

    a_ic_route: assert property (@(posedge clk) disable iff (!rst_n_i)
        ic_r_valid_o |-> rd_is_ic && !dc_r_valid_o)
        else report_problem("R beat routed to the icache for a dcache read");

    a_dc_route: assert property (@(posedge clk) disable iff (!rst_n_i)
        dc_r_valid_o |-> !rd_is_ic && !ic_r_valid_o)
        else report_problem("R beat routed to the dcache for an icache read");

    a_r_beat: assert property (@(posedge clk) disable iff (!rst_n_i)
        ic_r_valid_o || dc_r_valid_o |->
            {cache_r_o.data, cache_r_o.last} == {exp_rdata, exp_rlast})
        else report_fail("r beat", 64'({exp_rdata, exp_rlast}),
                         64'({cache_r_o.data, cache_r_o.last}));

    a_aw_fields: assert property (@(posedge clk) disable iff (!rst_n_i)
        awvalid_o && awready_i |-> aw_o == exp_aw && dc_aw_ready_o)
        else report_fail("aw payload", 64'(exp_aw), 64'(aw_o));

    a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        awvalid_o && !awready_i |=> awvalid_o && $stable(aw_o))
        else report_problem("AW valid or payload changed while awready was low");

    a_w_beat: assert property (@(posedge clk) disable iff (!rst_n_i)
        wvalid_o && wready_i |-> w_o == exp_w)
        else report_fail("w beat", 64'(exp_w), 64'(w_o));

    a_w_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        wvalid_o && !wready_i |=> wvalid_o && $stable(w_o))
        else report_problem("W beat dropped or changed while wready was low");

    a_w_ready: assert property (@(posedge clk) disable iff (!rst_n_i)
        wvalid_o |-> dc_w_ready_o == wready_i)
        else report_fail("dcache w ready", 64'(wready_i), 64'(dc_w_ready_o));

    a_bready_rise: assert property (@(posedge clk) disable iff (!rst_n_i)
        wvalid_o && wready_i && w_o.last |=> bready_o)
        else report_problem("bready did not rise after wlast");

    a_bready_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        bready_o && !bvalid_i |=> bready_o)
        else report_problem("bready dropped before bvalid");

    a_no_aw_in_resp: assert property (@(posedge clk) disable iff (!rst_n_i)
        bready_o |-> !awvalid_o)
        else report_problem("new AW issued before the B response");

    // slave model, read side
    initial begin : rd_slave
        logic              ar_hs;
        logic              r_hs;
        logic [ID_W-1:0]   id_s;
        logic [ADDR_W-1:0] addr_s;
        logic [7:0]        len_s;
        logic [7:0]        k;
        arready_i = 1'b0;
        rvalid_i  = 1'b0;
        r_i       = '0;
        k         = '0;
        forever begin
            @(negedge clk);
            ar_hs = arvalid_o && arready_i;
            r_hs  = rvalid_i && rready_o;
            if (ar_hs) begin
                id_s   = ar_o.id;
                addr_s = ar_o.addr;
                len_s  = ar_o.len;
            end
            @(posedge clk);
            #1;
            if (r_hs) begin
                if (r_i.last) begin
                    rvalid_i = 1'b0;
                end else begin
                    k = k + 8'd1;
                end
            end
            if (ar_hs) begin
                k        = '0;
                rvalid_i = 1'b1;
            end
            r_i.id    = id_s;
            r_i.data  = pattern_word(addr_s, k);
            r_i.resp  = 2'b00;
            r_i.last  = (k == len_s);
            arready_i = ($urandom_range(0, 3) != 0);  // stall one cycle in four
        end
    end

    // slave model, write side
    initial begin : wr_slave
        logic wlast_hs;
        logic b_hs;
        awready_i = 1'b0;
        wready_i  = 1'b0;
        bvalid_i  = 1'b0;
        bresp_i   = 2'b00;
        forever begin
            @(negedge clk);
            wlast_hs = wvalid_o && wready_i && w_o.last;
            b_hs     = bvalid_i && bready_o;
            @(posedge clk);
            #1;
            if (b_hs) bvalid_i = 1'b0;
            if (wlast_hs) bvalid_i = 1'b1;
            awready_i = ($urandom_range(0, 3) != 0);
            wready_i  = ($urandom_range(0, 2) != 0);
        end
    end

    // reference tracking of owner, beat and write counters
    initial begin : tracker
        logic       ar_hs;
        logic       ic_won;
        cache_req_t src;
        logic       r_beat;
        logic       aw_hs;
        logic [7:0] aw_cnt;
        logic       w_hs;
        last_was_ic = 1'b1;  // dcache goes first after reset
        rd_is_ic    = 1'b0;
        rd_addr     = '0;
        rd_cnt      = '0;
        beat_k      = '0;
        wr_cnt      = '0;
        w_k         = '0;
        forever begin
            @(negedge clk);
            ar_hs  = arvalid_o && arready_i;
            ic_won = exp_ic_wins;
            src    = exp_src;
            r_beat = ic_r_valid_o || dc_r_valid_o;
            aw_hs  = awvalid_o && awready_i;
            aw_cnt = dc_wr_i.cnt;
            w_hs   = wvalid_o && wready_i;
            @(posedge clk);
            #1;
            if (r_beat) beat_k = beat_k + 8'd1;
            if (ar_hs) begin
                rd_is_ic    = ic_won;
                last_was_ic = ic_won;
                rd_addr     = src.addr;
                rd_cnt      = src.cnt;
                beat_k      = '0;
            end
            if (w_hs) w_k = w_k + 8'd1;
            if (aw_hs) begin
                wr_cnt = aw_cnt;
                w_k    = '0;
            end
        end
    end

    // one or two read requests, returns once every burst has ended
    task automatic run_reads(input logic use_ic, input logic use_dc);
        int   want;
        int   bursts;
        logic drop_ic;
        logic drop_dc;
        logic burst_end;
        want   = int'(use_ic) + int'(use_dc);
        bursts = 0;
        if (use_ic) begin
            ic_req_i.addr = rand_addr();
            ic_req_i.cnt  = rand_cnt();
            ic_rd_req_i   = 1'b1;
        end
        if (use_dc) begin
            dc_req_i.addr = rand_addr();
            dc_req_i.cnt  = rand_cnt();
            dc_rd_req_i   = 1'b1;
        end
        while (bursts < want) begin
            @(negedge clk);
            drop_ic   = ic_ar_ready_o;
            drop_dc   = dc_ar_ready_o;
            burst_end = (ic_r_valid_o || dc_r_valid_o) && cache_r_o.last;
            @(posedge clk);
            #1;
            if (drop_ic) ic_rd_req_i = 1'b0;
            if (drop_dc) dc_rd_req_i = 1'b0;
            if (burst_end) bursts++;
        end
    endtask

    // returns after wlast, the B response may still be pending
    task automatic write_burst();
        int         i;
        logic [7:0] cnt;
        logic [7:0] j;
        logic       seen;
        cnt = rand_cnt();
        for (i = 0; i < 8; i++) begin
            wdata[i[2:0]] = $urandom();
            wstrb[i[2:0]] = 4'($urandom_range(1, 15));
        end
        dc_wr_i.addr = rand_addr();
        dc_wr_i.cnt  = cnt;
        dc_wr_req_i  = 1'b1;
        do begin
            @(negedge clk);
            seen = dc_aw_ready_o;
            @(posedge clk);
            #1;
        end while (!seen);
        dc_wr_req_i  = 1'b0;
        j            = '0;
        dc_w_valid_i = 1'b1;
        dc_w_i       = '{data: wdata[0], strb: wstrb[0], last: (cnt == 8'd1)};
        while (dc_w_valid_i) begin
            @(negedge clk);
            seen = dc_w_ready_o;
            @(posedge clk);
            #1;
            if (seen && dc_w_i.last) begin
                dc_w_valid_i = 1'b0;
            end else if (seen) begin
                j      = j + 8'd1;
                dc_w_i = '{data: wdata[j[2:0]], strb: wstrb[j[2:0]], last: (j == cnt - 8'd1)};
            end
        end
    endtask

    task automatic wait_write_resp();
        logic done;
        do begin
            @(negedge clk);
            done = bvalid_i && bready_o;
        end while (!done);
        @(posedge clk);
        #1;
    endtask

    initial begin : watchdog
        repeat (200 * N_TRANS) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run timed out", 200 * N_TRANS);
        $display("test failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h6b35));
        err_count    = 0;
        test_name    = "reset";
        rst_n_i      = 1'b0;
        ic_rd_req_i  = 1'b0;
        ic_req_i     = '0;
        dc_rd_req_i  = 1'b0;
        dc_req_i     = '0;
        dc_wr_req_i  = 1'b0;
        dc_wr_i      = '0;
        dc_w_valid_i = 1'b0;
        dc_w_i       = '0;
        repeat (5) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        repeat (2) @(posedge clk);
        #1;

        test_name = "icache_read";
        repeat (N_IC) run_reads(1'b1, 1'b0);
        test_name = "both_read";  // the icache owned the last read so the dcache wins
        run_reads(1'b1, 1'b1);
        test_name = "dcache_read";
        repeat (N_DC) run_reads(1'b0, 1'b1);
        test_name = "both_read";  // the dcache owned the last read so the icache wins
        repeat (N_BOTH - 1) run_reads(1'b1, 1'b1);
        test_name = "write";  // next request overlaps the previous B
        repeat (N_WR) write_burst();
        wait_write_resp();
        repeat (3) @(posedge clk);

        $display("checks done, %0d errors", err_count);
        if (err_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic clk_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial clk_o = 1'b0;

    always #5 clk_o = ~clk_o;  // 10 ns period

endmodule

`default_nettype wire
